/* logic/dft_pkg.sv */
/* shared sizes, wishbone bundles and the per-bank factor plan
   adr is {bank, offset}; offsets are sized for max_pts up to 64 */
package dft_pkg;

	// --------------------
	// sizes
	localparam int sample_w   = 16;
	localparam int pts_w      = 7;
	localparam int max_stages = 6;
	localparam int adr_w      = 7;

	// --------------------
	// wishbone classic, master to slave
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [adr_w-1:0]    adr;
		logic [sample_w-1:0] dat;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic                ack;
		logic [sample_w-1:0] dat;
	} wb_rsp_t;

	// one bank's plan; slots past num_factors hold factor 1
	typedef struct packed {
		logic [2:0]                        num_factors;
		logic [0:max_stages-1][2:0]        nf;
		logic [0:max_stages-1][pts_w-1:0]  pts_div_nf;
		logic [0:max_stages-1][pts_w-1:0]  twdl_den;
	} dft_plan_t;

endpackage

/* logic/dft_factor_ctrl.sv */
/* greedy factoring of N in the order 4, 2, 5, 3, one slot per cycle
   N must factor completely and stay within max_pts */
module dft_factor_ctrl #(
	parameter int max_pts = 64
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        frame_sop,
	input  logic [dft_pkg::pts_w-1:0]   frame_pts,
	input  logic                        frame_done,
	input  logic                        src_done,
	output logic                        sw_in,
	output logic                        bank_free,
	output logic                        sw_out,
	output logic                        src_start,
	output dft_pkg::dft_plan_t          plan
);
	localparam int pw = dft_pkg::pts_w;
	localparam int ns = dft_pkg::max_stages;

	dft_pkg::dft_plan_t work;
	dft_pkg::dft_plan_t plan_q [2];
	logic [pw-1:0] n_iter;
	logic [2:0]    cnt_q;
	logic [2:0]    nxt_f;
	logic          fact_bank;
	logic [1:0]    full_q;
	logic [1:0]    plan_rdy;
	logic          src_busy;

	// divide by one of the few radices, constant divisors only
	function automatic logic [dft_pkg::pts_w-1:0] div_f(
		input logic [dft_pkg::pts_w-1:0] x,
		input logic [2:0]                f
	);
		case (f)
			3'd2:    div_f = x >> 1;
			3'd3:    div_f = x / pw'(3);
			3'd4:    div_f = x >> 2;
			3'd5:    div_f = x / pw'(5);
			default: div_f = x;
		endcase
	endfunction

	// next factor by divisibility, 1 once n_iter is used up
	always_comb begin
		if (n_iter[1:0] == 2'b00 && n_iter != '0) nxt_f = 3'd4;
		else if (!n_iter[0] && n_iter != '0)     nxt_f = 3'd2;
		else if (n_iter % pw'(5) == '0)          nxt_f = 3'd5;
		else if (n_iter % pw'(3) == '0)          nxt_f = 3'd3;
		else                                     nxt_f = 3'd1;
	end

	// --------------------
	// factor pipe, cnt 1..6 fills slots 0..5, cnt 7 commits
	always_ff @(posedge clk) begin
		if (frame_sop) begin
			n_iter           <= frame_pts;
			work.num_factors <= '0;
			work.twdl_den[0] <= frame_pts;
			fact_bank        <= sw_in;
		end else if (cnt_q != 3'd0) begin
			n_iter <= div_f(n_iter, nxt_f);
			if (cnt_q != 3'd7 && nxt_f != 3'd1)
				work.num_factors <= work.num_factors + 3'd1;
			for (int j = 0; j < ns; j++) begin
				if (cnt_q == 3'(j + 1)) begin
					work.nf[j]         <= nxt_f;
					work.pts_div_nf[j] <= div_f(work.twdl_den[0], nxt_f);
				end
			end
			// den[j] = den[j-1] / factor[j-1]
			for (int j = 1; j < ns; j++) begin
				if (cnt_q == 3'(j))
					work.twdl_den[j] <= div_f(work.twdl_den[j-1], nxt_f);
			end
			if (cnt_q == 3'd7)
				plan_q[fact_bank] <= work;
		end
	end

	// --------------------
	// ping-pong flags and source kick
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_q     <= 3'd0;
			sw_in     <= 1'b0;
			sw_out    <= 1'b0;
			full_q    <= 2'b00;
			plan_rdy  <= 2'b00;
			src_busy  <= 1'b0;
			src_start <= 1'b0;
		end else begin
			src_start <= 1'b0;
			if (frame_sop)            cnt_q <= 3'd1;
			else if (cnt_q == 3'd7)   cnt_q <= 3'd0;
			else if (cnt_q != 3'd0)   cnt_q <= cnt_q + 3'd1;
			if (cnt_q == 3'd7)
				plan_rdy[fact_bank] <= 1'b1;
			// sink side fills sw_in, source side drains sw_out
			if (frame_done) begin
				full_q[sw_in] <= 1'b1;
				sw_in         <= !sw_in;
			end
			if (src_done) begin
				full_q[sw_out]   <= 1'b0;
				plan_rdy[sw_out] <= 1'b0;
				sw_out           <= !sw_out;
				src_busy         <= 1'b0;
			end
			if (!src_busy && full_q[sw_out] && plan_rdy[sw_out]) begin
				src_start <= 1'b1;
				src_busy  <= 1'b1;
			end
		end
	end

	assign bank_free = !full_q[sw_in];
	assign plan      = plan_q[sw_out];

	// at commit N must be used up by the six slots
	a_stage_bound: assert property (@(posedge clk) disable iff (!rst_n)
		(cnt_q == 3'd7) |-> (work.num_factors <= ns && n_iter == pw'(1)));
	a_pts_range: assert property (@(posedge clk) disable iff (!rst_n)
		frame_sop |-> (frame_pts <= max_pts));

endmodule

/* logic/frame_sink.sv */
/* one wishbone write per accepted beat, no overlap
   in_sop must mark the first beat of each frame */
module frame_sink #(
	parameter int max_pts = 64
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           in_valid,
	input  logic                           in_sop,
	input  logic [dft_pkg::pts_w-1:0]      in_pts,
	input  logic [dft_pkg::sample_w-1:0]   in_data,
	output logic                           in_ready,
	input  logic                           sw_in,
	input  logic                           bank_free,
	output logic                           frame_sop,
	output logic [dft_pkg::pts_w-1:0]      frame_pts,
	output logic                           frame_done,
	output dft_pkg::wb_req_t               wb_req,
	input  dft_pkg::wb_rsp_t               wb_rsp
);
	localparam int off_w = $clog2(max_pts);
	localparam int pw    = dft_pkg::pts_w;

	logic                          idle_q;
	logic                          cyc_q;
	logic                          last_q;
	logic [off_w-1:0]              off_q;
	logic [off_w-1:0]              off_cur;
	logic [pw-1:0]                 pts_q;
	logic [dft_pkg::adr_w-1:0]     adr_q;
	logic [dft_pkg::sample_w-1:0]  dat_q;
	logic                          take;

	// sw_in and bank_free still show the old bank while frame_done is high
	assign in_ready  = idle_q && bank_free && !frame_done;
	assign take      = in_valid && in_ready;
	assign off_cur   = in_sop ? '0 : off_q;
	assign frame_pts = pts_q;
	assign wb_req    = '{cyc: cyc_q, stb: cyc_q, we: 1'b1, adr: adr_q, dat: dat_q};

	// --------------------
	// bus handshake
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idle_q     <= 1'b0;
			cyc_q      <= 1'b0;
			frame_sop  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_sop  <= 1'b0;
			frame_done <= 1'b0;
			if (take) begin
				idle_q    <= 1'b0;
				cyc_q     <= 1'b1;
				frame_sop <= in_sop;
			end else if (cyc_q && wb_rsp.ack) begin
				cyc_q      <= 1'b0;
				idle_q     <= 1'b1;
				frame_done <= last_q;
			end else if (!cyc_q) begin
				idle_q <= 1'b1;
			end
		end
	end

	// beat payload and offset count; sop beat is never the last one (N >= 4)
	always_ff @(posedge clk) begin
		if (take) begin
			adr_q  <= dft_pkg::adr_w'({sw_in, off_cur});
			dat_q  <= in_data;
			off_q  <= off_cur + 1'b1;
			last_q <= !in_sop && (pw'(off_q) == pts_q - 1'b1);
			if (in_sop)
				pts_q <= in_pts;
		end
	end

	a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_req.stb && !wb_rsp.ack) |=> (wb_req.cyc && wb_req.stb && $stable(wb_req.adr)));

endmodule

/* logic/digit_rev_source.sv */
/* reads the source bank in mixed-radix digit-reversed order
   plan and sw_out must stay stable from src_start until src_done */
module digit_rev_source #(
	parameter int max_pts = 64
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           src_start,
	input  logic                           sw_out,
	input  dft_pkg::dft_plan_t             plan,
	output logic                           out_valid,
	input  logic                           out_ready,
	output logic [dft_pkg::sample_w-1:0]   out_data,
	output logic                           out_sop,
	output logic                           out_eop,
	output logic                           src_done,
	output dft_pkg::wb_req_t               wb_req,
	input  dft_pkg::wb_rsp_t               wb_rsp
);
	localparam int off_w = $clog2(max_pts);
	localparam int pw    = dft_pkg::pts_w;
	localparam int ns    = dft_pkg::max_stages;

	logic [0:ns-1][2:0]        dig_q;
	logic [0:ns-1][2:0]        dig_nxt;
	logic [0:ns-1][pw-1:0]     den_up;
	logic [pw-1:0]             addr_q;
	logic [pw-1:0]             addr_nxt;
	logic [pw-1:0]             cnt_q;
	logic                      cyc_q;
	logic [dft_pkg::adr_w-1:0] adr_q;
	logic                      ack;
	logic                      take;

	assign ack    = cyc_q && wb_rsp.ack;
	assign take   = out_valid && out_ready;
	assign wb_req = '{cyc: cyc_q, stb: cyc_q, we: 1'b0, adr: adr_q, dat: '0};

	// digit j weighs den[j+1], top digit weighs 1
	always_comb begin
		for (int j = 0; j < ns - 1; j++) begin
			den_up[j] = plan.twdl_den[j + 1];
		end
		den_up[ns-1] = pw'(1);
	end

	// --------------------
	// odometer step, digit 0 first
	always_comb begin
		logic carry;
		carry    = 1'b1;
		dig_nxt  = dig_q;
		addr_nxt = addr_q;
		for (int j = 0; j < ns; j++) begin
			if (carry) begin
				if (dig_q[j] == plan.nf[j] - 3'd1) begin
					// wrap, drop this digit's share
					dig_nxt[j] = 3'd0;
					addr_nxt   = addr_nxt - pw'(dig_q[j]) * den_up[j];
				end else begin
					dig_nxt[j] = dig_q[j] + 3'd1;
					addr_nxt   = addr_nxt + den_up[j];
					carry      = 1'b0;
				end
			end
		end
	end

	// read, present, wait for take, next read
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cyc_q     <= 1'b0;
			out_valid <= 1'b0;
			src_done  <= 1'b0;
		end else begin
			src_done <= 1'b0;
			if (src_start) begin
				cyc_q <= 1'b1;
			end else if (ack) begin
				cyc_q     <= 1'b0;
				out_valid <= 1'b1;
			end else if (take) begin
				out_valid <= 1'b0;
				src_done  <= out_eop;
				cyc_q     <= !out_eop;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (src_start) begin
			dig_q  <= '0;
			addr_q <= '0;
			cnt_q  <= '0;
			adr_q  <= dft_pkg::adr_w'({sw_out, off_w'(0)});
		end else if (ack) begin
			out_data <= wb_rsp.dat;
			out_sop  <= (cnt_q == '0);
			out_eop  <= (cnt_q == plan.twdl_den[0] - 1'b1);
			cnt_q    <= cnt_q + 1'b1;
			dig_q    <= dig_nxt;
			addr_q   <= addr_nxt;
		end else if (take) begin
			adr_q <= dft_pkg::adr_w'({sw_out, addr_q[off_w-1:0]});
		end
	end

endmodule

/* logic/wb_arbiter.sv */
/* two wishbone classic masters onto one slave, sink wins a tie
   grant switches with no idle cycle once the owner drops cyc */
module wb_arbiter #(
	parameter int max_pts = 64
) (
	input  logic              clk,
	input  logic              rst_n,
	input  dft_pkg::wb_req_t  sink_req,
	output dft_pkg::wb_rsp_t  sink_rsp,
	input  dft_pkg::wb_req_t  src_req,
	output dft_pkg::wb_rsp_t  src_rsp,
	output dft_pkg::wb_req_t  ram_req,
	input  dft_pkg::wb_rsp_t  ram_rsp
);
	// 0 sink, 1 source
	logic gnt_q;
	logic sel;
	logic held;

	assign held = gnt_q ? src_req.cyc : sink_req.cyc;

	always_comb begin
		if (held)              sel = gnt_q;
		else if (sink_req.cyc) sel = 1'b0;
		else if (src_req.cyc)  sel = 1'b1;
		else                   sel = gnt_q;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) gnt_q <= 1'b0;
		else        gnt_q <= sel;
	end

	// --------------------
	// routing, ack only to the owner
	assign ram_req = sel ? src_req : sink_req;

	always_comb begin
		sink_rsp     = ram_rsp;
		src_rsp      = ram_rsp;
		sink_rsp.ack = ram_rsp.ack && !sel;
		src_rsp.ack  = ram_rsp.ack && sel;
	end

	a_grant_held: assert property (@(posedge clk) disable iff (!rst_n)
		(ram_req.cyc && !ram_rsp.ack) |=> (sel == $past(sel)));

endmodule

/* logic/sample_ram.sv */
/* both frame banks in one single-port array
   ack one cycle after cyc and stb, never twice for a held request */
module sample_ram #(
	parameter int max_pts = 64
) (
	input  logic              clk,
	input  logic              rst_n,
	input  dft_pkg::wb_req_t  wb_req,
	output dft_pkg::wb_rsp_t  wb_rsp
);
	localparam int idx_w = $clog2(2 * max_pts);

	logic [dft_pkg::sample_w-1:0] mem [2 * max_pts];
	logic [dft_pkg::sample_w-1:0] rd_q;
	logic [idx_w-1:0]             idx;
	logic                         ack_q;
	logic                         req;

	// bank bit sits right above the offset
	assign idx = wb_req.adr[idx_w-1:0];
	assign req = wb_req.cyc && wb_req.stb && !ack_q;

	always_ff @(posedge clk) begin
		if (!rst_n) ack_q <= 1'b0;
		else        ack_q <= req;
	end

	// read data lands together with ack
	always_ff @(posedge clk) begin
		if (req) begin
			if (wb_req.we)
				mem[idx] <= wb_req.dat;
			rd_q <= mem[idx];
		end
	end

	assign wb_rsp = '{ack: ack_q, dat: rd_q};

endmodule

/* logic/dft_reorder_top.sv */
/* input reorder for a mixed-radix dft, ping-pong over two banks
   valid N: 4..max_pts, factoring completely into 4, 2, 5, 3 */
module dft_reorder_top #(
	parameter int max_pts = 64
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           in_valid,
	input  logic                           in_sop,
	input  logic [dft_pkg::pts_w-1:0]      in_pts,
	input  logic [dft_pkg::sample_w-1:0]   in_data,
	output logic                           in_ready,
	output logic                           out_valid,
	input  logic                           out_ready,
	output logic [dft_pkg::sample_w-1:0]   out_data,
	output logic                           out_sop,
	output logic                           out_eop
);
	logic sw_in, sw_out, bank_free, src_start, src_done, frame_sop, frame_done;
	logic [dft_pkg::pts_w-1:0] frame_pts;
	dft_pkg::dft_plan_t plan;
	dft_pkg::wb_req_t   sink_req, src_req, ram_req;
	dft_pkg::wb_rsp_t   sink_rsp, src_rsp, ram_rsp;

	dft_factor_ctrl #(.max_pts(max_pts)) i_ctrl (
		.clk(clk), .rst_n(rst_n), .frame_sop(frame_sop), .frame_pts(frame_pts),
		.frame_done(frame_done), .src_done(src_done), .sw_in(sw_in), .bank_free(bank_free),
		.sw_out(sw_out), .src_start(src_start), .plan(plan));

	frame_sink #(.max_pts(max_pts)) i_sink (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_sop(in_sop), .in_pts(in_pts),
		.in_data(in_data), .in_ready(in_ready), .sw_in(sw_in), .bank_free(bank_free),
		.frame_sop(frame_sop), .frame_pts(frame_pts), .frame_done(frame_done),
		.wb_req(sink_req), .wb_rsp(sink_rsp));

	digit_rev_source #(.max_pts(max_pts)) i_src (
		.clk(clk), .rst_n(rst_n), .src_start(src_start), .sw_out(sw_out), .plan(plan),
		.out_valid(out_valid), .out_ready(out_ready), .out_data(out_data), .out_sop(out_sop),
		.out_eop(out_eop), .src_done(src_done), .wb_req(src_req), .wb_rsp(src_rsp));

	// sink and source share the one ram port
	wb_arbiter #(.max_pts(max_pts)) i_arb (
		.clk(clk), .rst_n(rst_n), .sink_req(sink_req), .sink_rsp(sink_rsp),
		.src_req(src_req), .src_rsp(src_rsp), .ram_req(ram_req), .ram_rsp(ram_rsp));

	sample_ram #(.max_pts(max_pts)) i_ram (
		.clk(clk), .rst_n(rst_n), .wb_req(ram_req), .wb_rsp(ram_rsp));

endmodule

/* verification/tb_dft_reorder.sv */
/* random frames through the reorder engine, checked against a greedy-factoring model
   frames may follow each other with no idle cycle, so bank switches are exercised */
module tb_dft_reorder;

	localparam int max_pts    = 64;
	localparam int num_frames = 40;
	localparam int clk_period = 20;
	localparam int wd_time    = num_frames * max_pts * 8 * clk_period;
	localparam int pat_len    = 1024;

	typedef struct packed {
		logic                         sop;
		logic                         eop;
		logic [dft_pkg::sample_w-1:0] data;
	} beat_t;

	logic                          clk;
	logic                          rst_n;
	logic                          in_valid;
	logic                          in_sop;
	logic [dft_pkg::pts_w-1:0]     in_pts;
	logic [dft_pkg::sample_w-1:0]  in_data;
	logic                          in_ready;
	logic                          out_valid;
	logic                          out_ready;
	logic [dft_pkg::sample_w-1:0]  out_data;
	logic                          out_sop;
	logic                          out_eop;

	int valid_pts [12] = '{4, 8, 12, 16, 20, 24, 32, 36, 40, 48, 60, 64};
	logic [dft_pkg::sample_w-1:0] frame_buf [max_pts];
	logic ready_pat [pat_len];
	beat_t exp_q [$];
	int errors;
	int frames_in;
	int frames_out;

	dft_reorder_top #(.max_pts(max_pts)) i_dut (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_sop(in_sop), .in_pts(in_pts),
		.in_data(in_data), .in_ready(in_ready), .out_valid(out_valid), .out_ready(out_ready),
		.out_data(out_data), .out_sop(out_sop), .out_eop(out_eop));

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = !clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// --------------------
	// reference model
	// greedy factors 4, 2, 5, 3, then beat k reads sample r(k)
	task automatic queue_expected(input int n);
		int f [6];
		int den [7];
		int m;
		int rem;
		int r;
		beat_t b;
		m = n;
		for (int j = 0; j < 6; j++) begin
			if (m % 4 == 0)      f[j] = 4;
			else if (m % 2 == 0) f[j] = 2;
			else if (m % 5 == 0) f[j] = 5;
			else if (m % 3 == 0) f[j] = 3;
			else                 f[j] = 1;
			m = m / f[j];
		end
		// den[0] is N, each later one divided down by the factor before it
		den[0] = n;
		for (int j = 0; j < 6; j++)
			den[j + 1] = den[j] / f[j];
		for (int k = 0; k < n; k++) begin
			rem = k;
			r   = 0;
			// digit 0 least significant, radix f[0]
			for (int j = 0; j < 6; j++) begin
				r   = r + (rem % f[j]) * den[j + 1];
				rem = rem / f[j];
			end
			b.sop  = (k == 0);
			b.eop  = (k == n - 1);
			// single factor means plain order
			if (n == 4)
				b.data = frame_buf[k];
			else
				b.data = frame_buf[r];
			exp_q.push_back(b);
		end
	endtask

	// --------------------
	// input side
	task automatic send_beat(input logic sop, input int n,
			input logic [dft_pkg::sample_w-1:0] data);
		logic accepted;
		int gap;
		accepted = 1'b0;
		in_valid = 1'b1;
		in_sop   = sop;
		in_pts   = dft_pkg::pts_w'(n);
		in_data  = data;
		while (!accepted) begin
			// in_ready does not depend on in_valid, sample mid cycle
			@(negedge clk);
			accepted = in_ready;
			@(posedge clk);
			#2;
		end
		in_valid = 1'b0;
		in_sop   = 1'b0;
		// random idle beats inside a frame
		if ($urandom % 4 == 0) begin
			gap = 1 + int'($urandom % 3);
			repeat (gap) begin
				@(posedge clk);
				#2;
			end
		end
	endtask

	task automatic idle_cycles(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#2;
		end
	endtask

	initial begin : stimulus
		int n;
		void'($urandom(32'h29b0));
		errors     = 0;
		frames_in  = 0;
		frames_out = 0;
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_sop     = 1'b0;
		in_pts     = '0;
		in_data    = '0;
		// out_ready mostly high, pattern drawn up front
		for (int i = 0; i < pat_len; i++)
			ready_pat[i] = ($urandom % 4) != 0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		idle_cycles(2);
		for (int fr = 0; fr < num_frames; fr++) begin
			// first frame is the one-factor case
			if (fr == 0)
				n = 4;
			else
				n = valid_pts[$urandom_range(11, 0)];
			for (int i = 0; i < n; i++)
				frame_buf[i] = dft_pkg::sample_w'($urandom);
			queue_expected(n);
			for (int i = 0; i < n; i++)
				send_beat(i == 0, n, frame_buf[i]);
			frames_in++;
			// random gap between frames, often none
			idle_cycles(int'($urandom % 4));
		end
		while (frames_out < num_frames)
			@(posedge clk);
		// a few more cycles to catch stray beats
		idle_cycles(20);
		check_value("frames_out", 32'(frames_out), 32'(num_frames));
		if (exp_q.size() != 0) begin
			$display("%0d expected output beats never came out", exp_q.size());
			errors++;
		end
		$display("run complete: %0d errors over %0d frames", errors, frames_out);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// --------------------
	// output side
	initial begin : ready_drive
		int cyc;
		cyc       = 0;
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			#2;
			out_ready = rst_n && ready_pat[cyc % pat_len];
			cyc++;
		end
	end

	initial begin : monitor
		beat_t exp_b;
		beat_t held;
		logic  stalled;
		stalled = 1'b0;
		held    = '0;
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				check_value("out_valid", 32'(out_valid), 32'd0);
				check_value("in_ready", 32'(in_ready), 32'd0);
				stalled = 1'b0;
			end else begin
				// stalled beat must hold
				if (stalled) begin
					check_value("out_valid", 32'(out_valid), 32'd1);
					check_value("out_data", 32'(out_data), 32'(held.data));
					check_value("out_sop", 32'(out_sop), 32'(held.sop));
					check_value("out_eop", 32'(out_eop), 32'(held.eop));
				end
				// nothing before the first whole input frame
				if (frames_in == 0)
					check_value("out_valid", 32'(out_valid), 32'd0);
				if (out_valid && out_ready) begin
					if (exp_q.size() == 0) begin
						$display("output beat came out with no frame pending");
						errors++;
					end else begin
						exp_b = exp_q.pop_front();
						check_value("out_data", 32'(out_data), 32'(exp_b.data));
						check_value("out_sop", 32'(out_sop), 32'(exp_b.sop));
						check_value("out_eop", 32'(out_eop), 32'(exp_b.eop));
					end
					if (out_eop)
						frames_out++;
				end
				stalled   = out_valid && !out_ready;
				held.sop  = out_sop;
				held.eop  = out_eop;
				held.data = out_data;
			end
		end
	end

	// watchdog sized for every frame at max length
	initial begin : watchdog
		#(wd_time);
		$display("timeout: frames did not all come out, %0d of %0d seen",
			frames_out, num_frames);
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* vlog.f */
logic/dft_pkg.sv
logic/dft_factor_ctrl.sv
logic/frame_sink.sv
logic/digit_rev_source.sv
logic/wb_arbiter.sv
logic/sample_ram.sv
logic/dft_reorder_top.sv
verification/tb_dft_reorder.sv

/* run.sh */
#!/bin/sh
# build with verilator and run the reorder testbench

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_dft_reorder -o tb_dft_reorder > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/tb_dft_reorder > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -qx "TEST PASS" sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see sim.log"
exit 1
